// File: src/mpu_cfg_pkg.sv
// Region configuration struct, region table limits, bus widths and memory geometry
package mpu_cfg_pkg;

  ///////////////////////////////
  // Bus and memory geometry
  ///////////////////////////////

  // Address and data width of the load/store port
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Word memory behind the unit, indexed by address bits 7:2
  localparam int unsigned MEM_WORDS = 64;

  ///////////////////////////////
  // Region table
  ///////////////////////////////

  // Upper bound on the number of table entries
  localparam int unsigned MAX_REGIONS = 8;

  // One table entry; base and limit are both inclusive
  typedef struct packed {
    logic [31:0] base;
    logic [31:0] limit;
    logic        rd_en;
    logic        wr_en;
    logic        main;
  } region_cfg_t;

  // Default table, anything above 0xFF is unmapped
  localparam region_cfg_t DEFAULT_REGIONS [4] = '{
    '{base: 32'h0000_0000, limit: 32'h0000_003F, rd_en: 1'b1, wr_en: 1'b1, main: 1'b1},
    '{base: 32'h0000_0040, limit: 32'h0000_007F, rd_en: 1'b1, wr_en: 1'b0, main: 1'b1},
    '{base: 32'h0000_0080, limit: 32'h0000_00BF, rd_en: 1'b1, wr_en: 1'b1, main: 1'b0},
    '{base: 32'h0000_00C0, limit: 32'h0000_00FF, rd_en: 1'b0, wr_en: 1'b1, main: 1'b0}
  };

endpackage

// File: src/mpu_bus_pkg.sv
// Core response status encoding and the fault filter state encoding
package mpu_bus_pkg;

  ///////////////////////////////
  // Response status
  ///////////////////////////////

  // Status returned with every core response
  typedef enum logic [1:0] {
    RESP_OK       = 2'b00,
    RESP_RD_FAULT = 2'b01,
    RESP_WR_FAULT = 2'b10
  } resp_status_e;

  ///////////////////////////////
  // Filter FSM
  ///////////////////////////////

  // WAIT states drain the bus, RESP states pulse the fault response
  typedef enum logic [2:0] {
    MPU_IDLE    = 3'd0,
    MPU_RD_WAIT = 3'd1,
    MPU_WR_WAIT = 3'd2,
    MPU_RD_RESP = 3'd3,
    MPU_WR_RESP = 3'd4
  } mpu_state_e;

endpackage

// File: src/pma_region.sv
// Single PMA region checker: inclusive range match and attribute outputs
`timescale 1ns/1ps

module pma_region #(
  // Table entry handled by this checker
  parameter mpu_cfg_pkg::region_cfg_t CFG = '0
) (
  input  logic [mpu_cfg_pkg::ADDR_W-1:0] addr_i,
  output logic                           match_o,
  output logic                           rd_en_o,
  output logic                           wr_en_o,
  output logic                           main_o
);

  logic above_base;
  logic below_limit;

  // Both bounds are inclusive
  assign above_base  = (addr_i >= CFG.base);
  assign below_limit = (addr_i <= CFG.limit);

  // Region hit
  assign match_o = above_base && below_limit;

  // Attributes are static per region
  // Only meaningful while match_o is high
  assign rd_en_o = CFG.rd_en;
  assign wr_en_o = CFG.wr_en;
  assign main_o  = CFG.main;

endmodule

// File: src/pma_resolve.sv
// Priority resolver over all region results, producing one fault decision
`timescale 1ns/1ps

module pma_resolve #(
  parameter int unsigned NUM_REGIONS = 4
) (
  input  logic [NUM_REGIONS-1:0] match_i,
  input  logic [NUM_REGIONS-1:0] rd_en_i,
  input  logic [NUM_REGIONS-1:0] wr_en_i,
  input  logic [NUM_REGIONS-1:0] main_i,
  input  logic                   we_i,
  input  logic [1:0]             addr_lsb_i,
  output logic                   fault_o
);

  logic hit;
  logic sel_rd;
  logic sel_wr;
  logic sel_main;
  logic misaligned;

  // Table size must stay within the supported range
  if ((NUM_REGIONS < 1) || (NUM_REGIONS > mpu_cfg_pkg::MAX_REGIONS)) begin : g_bad_size
    $error("pma_resolve: NUM_REGIONS out of range");
  end

  // Walk from the top down so the lowest matching index wins
  always_comb begin
    hit      = 1'b0;
    sel_rd   = 1'b0;
    sel_wr   = 1'b0;
    sel_main = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        hit      = 1'b1;
        sel_rd   = rd_en_i[i];
        sel_wr   = wr_en_i[i];
        sel_main = main_i[i];
      end
    end
  end

  // Word accesses only, any low bit set is misaligned
  assign misaligned = |addr_lsb_i;

  // Unmapped, missing permission, or misaligned outside main memory
  assign fault_o = !hit
                || ( we_i && !sel_wr)
                || (!we_i && !sel_rd)
                || (misaligned && !sel_main);

endmodule

// File: src/mpu_filter.sv
// Fault-consuming filter FSM, outstanding access counter, bus forwarding and response merge
`timescale 1ns/1ps

module mpu_filter (
  input  logic                             clk,
  input  logic                             rst_n,

  // Core request
  input  logic                             core_valid_i,
  input  logic [mpu_cfg_pkg::ADDR_W-1:0]   core_addr_i,
  input  logic                             core_we_i,
  input  logic [mpu_cfg_pkg::DATA_W-1:0]   core_wdata_i,
  output logic                             core_ready_o,

  // Region check
  input  logic                             chk_fault_i,
  output logic [mpu_cfg_pkg::ADDR_W-1:0]   chk_addr_o,

  // Bus request
  output logic                             bus_valid_o,
  output logic [mpu_cfg_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic                             bus_we_o,
  output logic [mpu_cfg_pkg::DATA_W-1:0]   bus_wdata_o,
  input  logic                             bus_ready_i,

  // Bus response
  input  logic                             bus_rvalid_i,
  input  logic [mpu_cfg_pkg::DATA_W-1:0]   bus_rdata_i,

  // Core response, always accepted
  output logic                             core_resp_valid_o,
  output logic [mpu_cfg_pkg::DATA_W-1:0]   core_resp_rdata_o,
  output mpu_bus_pkg::resp_status_e        core_resp_status_o
);

  mpu_bus_pkg::mpu_state_e   state_q;
  mpu_bus_pkg::mpu_state_e   state_n;
  mpu_bus_pkg::resp_status_e err_status;
  logic [1:0]                out_cnt_q;
  logic                      fault_req;
  logic                      block_core;
  logic                      block_bus;
  logic                      err_ready;
  logic                      err_valid;
  logic                      bus_accept;
  logic                      cnt_drained;

  // Failing access offered by the core
  assign fault_req = core_valid_i && chk_fault_i;

  // Count is zero next cycle, no new bus access can start while a fault is pending
  assign cnt_drained = (out_cnt_q == 2'd0) || ((out_cnt_q == 2'd1) && bus_rvalid_i);

  //////////////////////////////
  // Fault FSM
  //////////////////////////////

  always_comb begin
    state_n    = state_q;
    block_core = 1'b0;
    block_bus  = 1'b0;
    err_ready  = 1'b0;
    err_valid  = 1'b0;
    err_status = mpu_bus_pkg::RESP_OK;
    case (state_q)
      mpu_bus_pkg::MPU_IDLE: begin
        if (fault_req) begin
          // Consume the access here, it never reaches the bus
          block_bus = 1'b1;
          err_ready = 1'b1;
          if (core_we_i) begin
            state_n = cnt_drained ? mpu_bus_pkg::MPU_WR_RESP : mpu_bus_pkg::MPU_WR_WAIT;
          end else begin
            state_n = cnt_drained ? mpu_bus_pkg::MPU_RD_RESP : mpu_bus_pkg::MPU_RD_WAIT;
          end
        end
      end
      mpu_bus_pkg::MPU_RD_WAIT, mpu_bus_pkg::MPU_WR_WAIT: begin
        // Hold off new traffic until earlier accesses return
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (cnt_drained) begin
          state_n = (state_q == mpu_bus_pkg::MPU_RD_WAIT) ? mpu_bus_pkg::MPU_RD_RESP
                                                           : mpu_bus_pkg::MPU_WR_RESP;
        end
      end
      mpu_bus_pkg::MPU_RD_RESP, mpu_bus_pkg::MPU_WR_RESP: begin
        // Single-cycle fault response, core never stalls it
        block_core = 1'b1;
        block_bus  = 1'b1;
        err_valid  = 1'b1;
        err_status = (state_q == mpu_bus_pkg::MPU_RD_RESP) ? mpu_bus_pkg::RESP_RD_FAULT
                                                           : mpu_bus_pkg::RESP_WR_FAULT;
        state_n    = mpu_bus_pkg::MPU_IDLE;
      end
      default: begin
        state_n = mpu_bus_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_bus_pkg::MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////

  assign bus_accept = bus_valid_o && bus_ready_i;

  // At most two accesses in flight with the two-stage memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= 2'd0;
    end else begin
      case ({bus_accept, bus_rvalid_i})
        2'b10:   out_cnt_q <= out_cnt_q + 2'd1;
        2'b01:   out_cnt_q <= out_cnt_q - 2'd1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // Forwarding and merge
  //////////////////////////////

  // Region check sees the raw core address
  assign chk_addr_o = core_addr_i;

  // Request fields pass straight through
  assign bus_valid_o = core_valid_i && !block_bus;
  assign bus_addr_o  = core_addr_i;
  assign bus_we_o    = core_we_i;
  assign bus_wdata_o = core_wdata_i;

  // Faults are taken regardless of bus stall
  assign core_ready_o = (bus_ready_i && !block_core) || err_ready;

  // Bus and fault responses never collide since RESP waits for the drain
  assign core_resp_valid_o  = bus_rvalid_i || err_valid;
  assign core_resp_rdata_o  = err_valid ? '0 : bus_rdata_i;
  assign core_resp_status_o = err_status;

endmodule

// File: src/mem_target.sv
// Pipelined word memory with two-cycle read latency and acceptance stall
`timescale 1ns/1ps

module mem_target (
  input  logic                           clk,
  input  logic                           rst_n,

  // Request side
  input  logic                           bus_valid_i,
  input  logic [mpu_cfg_pkg::ADDR_W-1:0] bus_addr_i,
  input  logic                           bus_we_i,
  input  logic [mpu_cfg_pkg::DATA_W-1:0] bus_wdata_i,
  input  logic                           stall_i,
  output logic                           bus_ready_o,

  // Response side
  output logic                           bus_rvalid_o,
  output logic [mpu_cfg_pkg::DATA_W-1:0] bus_rdata_o
);

  localparam int unsigned IDX_W = $clog2(mpu_cfg_pkg::MEM_WORDS);

  logic [mpu_cfg_pkg::DATA_W-1:0] mem_q [mpu_cfg_pkg::MEM_WORDS];
  logic [IDX_W-1:0]               idx;
  logic                           accept;
  logic                           s1_valid_q;
  logic                           s2_valid_q;
  logic [mpu_cfg_pkg::DATA_W-1:0] s1_rdata_q;
  logic [mpu_cfg_pkg::DATA_W-1:0] s2_rdata_q;

  // Stall only blocks new requests
  assign bus_ready_o = !stall_i;
  assign accept      = bus_valid_i && bus_ready_o;

  // Word index from address bits above the byte offset
  assign idx = bus_addr_i[IDX_W+1:2];

  // Array starts out zero, writes land at acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < int'(mpu_cfg_pkg::MEM_WORDS); i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && bus_we_i) begin
      mem_q[idx] <= bus_wdata_i;
    end
  end

  //////////////////////////////
  // Response pipeline
  //////////////////////////////

  // Valid bits, one access per stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= accept;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Data stages, writes answer with zero
  always_ff @(posedge clk) begin
    s1_rdata_q <= bus_we_i ? '0 : mem_q[idx];
    s2_rdata_q <= s1_rdata_q;
  end

  assign bus_rvalid_o = s2_valid_q;
  assign bus_rdata_o  = s2_rdata_q;

endmodule

// File: src/mpu_top.sv
// Top level wiring the fault filter, region checkers, priority resolver and word memory
`timescale 1ns/1ps

module mpu_top #(
  parameter int unsigned              NUM_REGIONS             = 4,
  parameter mpu_cfg_pkg::region_cfg_t REGION_CFG [NUM_REGIONS] = mpu_cfg_pkg::DEFAULT_REGIONS
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           core_valid_i,
  input  logic [mpu_cfg_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                           core_we_i,
  input  logic [mpu_cfg_pkg::DATA_W-1:0] core_wdata_i,
  output logic                           core_ready_o,
  output logic                           core_resp_valid_o,
  output logic [mpu_cfg_pkg::DATA_W-1:0] core_resp_rdata_o,
  output mpu_bus_pkg::resp_status_e      core_resp_status_o,
  input  logic                           bus_stall_i
);

  logic [mpu_cfg_pkg::ADDR_W-1:0] chk_addr;
  logic                           chk_fault;
  logic [NUM_REGIONS-1:0]         reg_match;
  logic [NUM_REGIONS-1:0]         reg_rd_en;
  logic [NUM_REGIONS-1:0]         reg_wr_en;
  logic [NUM_REGIONS-1:0]         reg_main;
  logic                           bus_valid;
  logic [mpu_cfg_pkg::ADDR_W-1:0] bus_addr;
  logic                           bus_we;
  logic [mpu_cfg_pkg::DATA_W-1:0] bus_wdata;
  logic                           bus_ready;
  logic                           bus_rvalid;
  logic [mpu_cfg_pkg::DATA_W-1:0] bus_rdata;

  // Filter between core port and memory bus
  mpu_filter u_filter (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_valid_i       (core_valid_i),
    .core_addr_i        (core_addr_i),
    .core_we_i          (core_we_i),
    .core_wdata_i       (core_wdata_i),
    .core_ready_o       (core_ready_o),
    .chk_fault_i        (chk_fault),
    .chk_addr_o         (chk_addr),
    .bus_valid_o        (bus_valid),
    .bus_addr_o         (bus_addr),
    .bus_we_o           (bus_we),
    .bus_wdata_o        (bus_wdata),
    .bus_ready_i        (bus_ready),
    .bus_rvalid_i       (bus_rvalid),
    .bus_rdata_i        (bus_rdata),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o)
  );

  // One checker per table entry
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region
    pma_region #(
      .CFG (REGION_CFG[i])
    ) u_region (
      .addr_i  (chk_addr),
      .match_o (reg_match[i]),
      .rd_en_o (reg_rd_en[i]),
      .wr_en_o (reg_wr_en[i]),
      .main_o  (reg_main[i])
    );
  end

  // Lowest index wins
  pma_resolve #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_resolve (
    .match_i    (reg_match),
    .rd_en_i    (reg_rd_en),
    .wr_en_i    (reg_wr_en),
    .main_i     (reg_main),
    .we_i       (core_we_i),
    .addr_lsb_i (chk_addr[1:0]),
    .fault_o    (chk_fault)
  );

  mem_target u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_valid_i  (bus_valid),
    .bus_addr_i   (bus_addr),
    .bus_we_i     (bus_we),
    .bus_wdata_i  (bus_wdata),
    .stall_i      (bus_stall_i),
    .bus_ready_o  (bus_ready),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata)
  );

endmodule

// File: test/mpu_top_assert.sv
// Concurrent assertions on the filter FSM, its outstanding count and the core response port
`timescale 1ns/1ps

module mpu_top_assert (
  input logic                      clk,
  input logic                      rst_n,
  input mpu_bus_pkg::mpu_state_e   state_i,
  input logic [1:0]                out_cnt_i,
  input logic                      bus_valid_i,
  input logic                      resp_valid_i,
  input mpu_bus_pkg::resp_status_e resp_status_i
);

  logic in_wait;
  logic in_resp;

  // Drain and answer phases of a consumed fault
  assign in_wait = (state_i == mpu_bus_pkg::MPU_RD_WAIT) || (state_i == mpu_bus_pkg::MPU_WR_WAIT);
  assign in_resp = (state_i == mpu_bus_pkg::MPU_RD_RESP) || (state_i == mpu_bus_pkg::MPU_WR_RESP);

  // No bus traffic while a fault is pending
  a_bus_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (in_wait || in_resp) |-> !bus_valid_i)
    else $error("bus_valid_o high while the filter blocks traffic");

  // RESP pulses a response and it is never OK
  a_fault_status: assert property (@(posedge clk) disable iff (!rst_n)
    in_resp |-> (resp_valid_i && (resp_status_i != mpu_bus_pkg::RESP_OK)))
    else $error("fault response missing or carrying OK status");

  // Responses only come from the bus or from RESP
  a_resp_source: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> ((out_cnt_i != 2'd0) || in_resp))
    else $error("response with nothing in flight and no fault pending");

endmodule

// File: test/mpu_checker.sv
// Reference model of region table and word memory, expected-response queue and comparison
`timescale 1ns/1ps

module mpu_checker #(
  parameter int unsigned              NUM_REGIONS             = 4,
  parameter mpu_cfg_pkg::region_cfg_t REGION_CFG [NUM_REGIONS] = mpu_cfg_pkg::DEFAULT_REGIONS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      core_valid_i,
  input  logic [31:0]               core_addr_i,
  input  logic                      core_we_i,
  input  logic [31:0]               core_wdata_i,
  input  logic                      core_ready_i,
  input  logic                      bus_stall_i,
  input  logic                      core_resp_valid_i,
  input  logic [31:0]               core_resp_rdata_i,
  input  mpu_bus_pkg::resp_status_e core_resp_status_i,
  input  logic                      report_i,
  input  logic [15:0]               timeout_count_i,
  output logic [15:0]               error_count_o,
  output logic [15:0]               pending_o
);

  logic [31:0]               mem_model [64];
  mpu_bus_pkg::resp_status_e exp_status_q [$];
  logic [31:0]               exp_rdata_q [$];
  logic [31:0]               exp_addr_q [$];
  mpu_bus_pkg::resp_status_e exp_status;
  logic [31:0]               exp_rdata;
  logic [31:0]               exp_addr;
  logic                      fault_pending;
  logic                      req_fault;
  int                        error_count;
  int                        accept_count;
  int                        resp_count;
  int                        fault_count;

  // Lowest matching entry decides
  // No match at all faults
  function automatic logic model_fault(input logic [31:0] addr, input logic we);
    for (int i = 0; i < int'(NUM_REGIONS); i++) begin
      if ((addr >= REGION_CFG[i].base) && (addr <= REGION_CFG[i].limit)) begin
        if (we && !REGION_CFG[i].wr_en) begin
          return 1'b1;
        end
        if (!we && !REGION_CFG[i].rd_en) begin
          return 1'b1;
        end
        // Misalignment only tolerated in main memory
        if ((addr[1:0] != 2'b00) && !REGION_CFG[i].main) begin
          return 1'b1;
        end
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  initial begin
    error_count   = 0;
    accept_count  = 0;
    resp_count    = 0;
    fault_count   = 0;
    fault_pending = 1'b0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        mem_model[i] = '0;
      end
      exp_status_q.delete();
      exp_rdata_q.delete();
      exp_addr_q.delete();
      fault_pending = 1'b0;
      pending_o     = '0;
    end else begin
      req_fault = model_fault(core_addr_i, core_we_i);
      // Core is held off from the cycle after a faulting acceptance until its response
      if (fault_pending && core_ready_i) begin
        $display("error: core_ready_o got %h expected %h while a fault is pending",
                 core_ready_i, 1'b0);
        error_count++;
      end
      // A fault is taken at once whatever the stall
      if (core_valid_i && req_fault && !fault_pending && !core_ready_i) begin
        $display("error: core_ready_o got %h expected %h for fault at %h",
                 core_ready_i, 1'b1, core_addr_i);
        error_count++;
      end
      ///////////////////////////////
      // Responses compared oldest first
      ///////////////////////////////
      if (core_resp_valid_i) begin
        resp_count++;
        if (exp_status_q.size() == 0) begin
          $display("response seen with no accepted access outstanding");
          error_count++;
        end else begin
          exp_status = exp_status_q.pop_front();
          exp_rdata  = exp_rdata_q.pop_front();
          exp_addr   = exp_addr_q.pop_front();
          if (core_resp_status_i != exp_status) begin
            $display("error: core_resp_status_o got %h expected %h at addr %h",
                     core_resp_status_i, exp_status, exp_addr);
            error_count++;
          end
          if (core_resp_rdata_i != exp_rdata) begin
            $display("error: core_resp_rdata_o got %h expected %h at addr %h",
                     core_resp_rdata_i, exp_rdata, exp_addr);
            error_count++;
          end
          if (exp_status != mpu_bus_pkg::RESP_OK) fault_pending = 1'b0;
        end
      end
      ///////////////////////////////
      // Request side
      ///////////////////////////////
      if (core_valid_i && core_ready_i) begin
        accept_count++;
        exp_addr_q.push_back(core_addr_i);
        if (req_fault) begin
          // Faulting write leaves the model untouched
          exp_status_q.push_back(core_we_i ? mpu_bus_pkg::RESP_WR_FAULT
                                           : mpu_bus_pkg::RESP_RD_FAULT);
          exp_rdata_q.push_back('0);
          fault_pending = 1'b1;
          fault_count++;
        end else begin
          if (bus_stall_i) begin
            $display("passing access at %h was accepted while the bus was stalled",
                     core_addr_i);
            error_count++;
          end
          exp_status_q.push_back(mpu_bus_pkg::RESP_OK);
          if (core_we_i) begin
            mem_model[core_addr_i[7:2]] = core_wdata_i;
            exp_rdata_q.push_back('0);
          end else begin
            exp_rdata_q.push_back(mem_model[core_addr_i[7:2]]);
          end
        end
      end
      // Accepted accesses still waiting for their response
      pending_o = 16'(exp_status_q.size());
    end
  end

  assign error_count_o = error_count[15:0];

  // Closing summary
  always @(posedge report_i) begin
    $display("accepted=%0d responses=%0d faults=%0d errors=%0d timeouts=%0d",
             accept_count, resp_count, fault_count, error_count, timeout_count_i);
  end

endmodule

// File: test/tb_mpu_top.sv
// Testbench top: clock, reset, LCG stimulus, DUT, checker, bound assertions and final verdict
`timescale 1ns/1ps

module tb_mpu_top;

  localparam int unsigned NUM_ACCESSES  = 400;
  localparam int          READY_TIMEOUT = 50;
  localparam int          DRAIN_TIMEOUT = 50;
  localparam logic [31:0] SEED          = 32'h3ea1_64b6;

  logic                      clk;
  logic                      rst_n;
  logic                      core_valid;
  logic [31:0]               core_addr;
  logic                      core_we;
  logic [31:0]               core_wdata;
  logic                      core_ready;
  logic                      core_resp_valid;
  logic [31:0]               core_resp_rdata;
  mpu_bus_pkg::resp_status_e core_resp_status;
  logic                      bus_stall;
  logic                      report;
  logic [15:0]               chk_errors;
  logic [15:0]               chk_pending;
  logic [15:0]               timeouts;
  logic                      timed_out;
  logic [31:0]               lcg_state;

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  mpu_top #(
    .NUM_REGIONS (4),
    .REGION_CFG  (mpu_cfg_pkg::DEFAULT_REGIONS)
  ) u_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_valid_i       (core_valid),
    .core_addr_i        (core_addr),
    .core_we_i          (core_we),
    .core_wdata_i       (core_wdata),
    .core_ready_o       (core_ready),
    .core_resp_valid_o  (core_resp_valid),
    .core_resp_rdata_o  (core_resp_rdata),
    .core_resp_status_o (core_resp_status),
    .bus_stall_i        (bus_stall)
  );

  // Same table as the DUT
  mpu_checker #(
    .NUM_REGIONS (4),
    .REGION_CFG  (mpu_cfg_pkg::DEFAULT_REGIONS)
  ) u_check (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_valid_i       (core_valid),
    .core_addr_i        (core_addr),
    .core_we_i          (core_we),
    .core_wdata_i       (core_wdata),
    .core_ready_i       (core_ready),
    .bus_stall_i        (bus_stall),
    .core_resp_valid_i  (core_resp_valid),
    .core_resp_rdata_i  (core_resp_rdata),
    .core_resp_status_i (core_resp_status),
    .report_i           (report),
    .timeout_count_i    (timeouts),
    .error_count_o      (chk_errors),
    .pending_o          (chk_pending)
  );

  bind mpu_filter mpu_top_assert u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .state_i       (state_q),
    .out_cnt_i     (out_cnt_q),
    .bus_valid_i   (bus_valid_o),
    .resp_valid_i  (core_resp_valid_o),
    .resp_status_i (core_resp_status_o)
  );

  ///////////////////////////////
  // Stimulus helpers
  ///////////////////////////////

  // Plain LCG, upper bits carry the useful randomness
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // About one cycle in four stalled
  task automatic pick_stall();
    logic [31:0] r;
    r = next_rand();
    bus_stall = (r[31:30] == 2'b00);
  endtask

  task automatic idle_cycle();
    core_valid = 1'b0;
    pick_stall();
    @(negedge clk);
  endtask

  // Offer one access and hold it until taken
  task automatic issue_access();
    logic [31:0] r;
    logic [31:0] r2;
    logic        accepted;
    int          waited;
    r  = next_rand();
    r2 = next_rand();
    waited   = 0;
    accepted = 1'b0;
    // 0x000 to 0x13F covers all regions plus unmapped space
    core_addr = {16'h0000, r[31:16]} % 32'd320;
    if (r2[31]) core_addr[1:0] = 2'b00;
    core_we    = r2[30];
    core_wdata = next_rand();
    core_valid = 1'b1;
    while (!accepted && !timed_out) begin
      pick_stall();
      #1;
      accepted = core_ready;
      @(negedge clk);
      waited++;
      if (!accepted && (waited >= READY_TIMEOUT)) begin
        $display("timeout: core_ready_o stayed low for %0d cycles at addr %h", waited, core_addr);
        timeouts++;
        timed_out = 1'b1;
      end
    end
    core_valid = 1'b0;
  endtask

  // Let every accepted access answer
  task automatic drain_responses();
    int waited;
    waited     = 0;
    core_valid = 1'b0;
    bus_stall  = 1'b0;
    while ((chk_pending != 16'd0) && (waited < DRAIN_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end
    if (chk_pending != 16'd0) begin
      $display("timeout: %0d responses still missing after the drain", chk_pending);
      timeouts++;
    end
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    rst_n      = 1'b0;
    core_valid = 1'b0;
    core_addr  = '0;
    core_we    = 1'b0;
    core_wdata = '0;
    bus_stall  = 1'b0;
    report     = 1'b0;
    timeouts   = '0;
    timed_out  = 1'b0;
    lcg_state  = SEED;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int n = 0; n < int'(NUM_ACCESSES); n++) begin
      if (!timed_out) begin
        // Occasional gap between accesses
        if (next_rand() < 32'h2000_0000) idle_cycle();
        issue_access();
      end
    end
    drain_responses();
    report = 1'b1;
    #1;
    if ((chk_errors == 16'd0) && (timeouts == 16'd0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: mpu_top.f
src/mpu_cfg_pkg.sv
src/mpu_bus_pkg.sv
src/pma_region.sv
src/pma_resolve.sv
src/mpu_filter.sv
src/mem_target.sv
src/mpu_top.sv
test/mpu_top_assert.sv
test/mpu_checker.sv
test/tb_mpu_top.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         := tb_mpu_top
FILELIST    := mpu_top.f
BUILD_FLAGS := --binary --timing --assert
LINT_FLAGS  := --lint-only --timing --assert -Wall
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_MSG    := Regression failed
PASS_MSG    := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a pass line"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
